//--- Makefile
# Verilator build, run and lint for the pipeline core

VERILATOR ?= verilator
TOP       ?= tbPipelineCore
RTL_TOP   ?= pipelineCore
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/10ps
JOBS      ?= 0
PASS_TEXT ?= TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the pass line appears in the simulation output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- hw/corePkg.sv
`include "core_config.svh"

package corePkg;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////////////////////////////////////////

    // Primary opcodes with their MIPS values
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDI    = 6'h08,
        OP_SLTI    = 6'h0A,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E,
        OP_LUI     = 6'h0F
    } opcode_e;

    // R-type funct codes that are implemented
    typedef enum logic [5:0] {
        FN_SLL = 6'h00,
        FN_SRL = 6'h02,
        FN_SRA = 6'h03,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_XOR = 6'h26,
        FN_NOR = 6'h27,
        FN_SLT = 6'h2A
    } funct_e;

    // Internal ALU operation
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } aluOp_e;

    ////////////////////////////////////////////////////////////////////////////
    // Stage payloads
    ////////////////////////////////////////////////////////////////////////////

    // Decode to execute
    typedef struct packed {
        logic                       valid;
        aluOp_e                     aluOp;
        logic                       useImm;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`REG_ADDR_WIDTH-1:0] dest;
        logic [`SHAMT_WIDTH-1:0]    shamt;
        logic [`DATA_WIDTH-1:0]     regA;
        logic [`DATA_WIDTH-1:0]     regB;
        logic [`DATA_WIDTH-1:0]     imm;
    } decodedOp_t;

    // Execute to result, and result to register file
    typedef struct packed {
        logic                       write;
        logic [`REG_ADDR_WIDTH-1:0] dest;
        logic [`DATA_WIDTH-1:0]     data;
    } wbResult_t;

endpackage

//--- hw/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////

// Register and operand width
`define DATA_WIDTH 32

// Register index width and register count
`define REG_ADDR_WIDTH 5
`define REG_COUNT 32

// Instruction field widths
`define SHAMT_WIDTH 5
`define IMM_WIDTH 16

`endif

//--- hw/decodeStage.sv
`timescale 1ns/10ps
`include "core_config.svh"

module decodeStage (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_instrValid,
    input  logic [`DATA_WIDTH-1:0]     i_instr,
    input  logic [`DATA_WIDTH-1:0]     i_rdDataA,
    input  logic [`DATA_WIDTH-1:0]     i_rdDataB,
    output logic [`REG_ADDR_WIDTH-1:0] o_rdAddrA,
    output logic [`REG_ADDR_WIDTH-1:0] o_rdAddrB,
    output corePkg::decodedOp_t        o_decoded
);

    localparam int EXT_WIDTH = `DATA_WIDTH - `IMM_WIDTH;

    corePkg::opcode_e           opcode;
    corePkg::funct_e            funct;
    logic [`REG_ADDR_WIDTH-1:0] rs;
    logic [`REG_ADDR_WIDTH-1:0] rt;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`SHAMT_WIDTH-1:0]    shamt;
    logic [`IMM_WIDTH-1:0]      imm16;
    logic                       known;
    corePkg::aluOp_e            aluOp;
    logic                       useImm;
    logic [`REG_ADDR_WIDTH-1:0] dest;
    logic [`DATA_WIDTH-1:0]     immExt;
    corePkg::decodedOp_t        decodedReg;

    ////////////////////////////////////////////////////////////////////////////
    // Field extraction
    ////////////////////////////////////////////////////////////////////////////

    assign opcode = corePkg::opcode_e'(i_instr[31:26]);
    assign rs     = i_instr[25:21];
    assign rt     = i_instr[20:16];
    assign rd     = i_instr[15:11];
    assign shamt  = i_instr[10:6];
    assign funct  = corePkg::funct_e'(i_instr[5:0]);
    assign imm16  = i_instr[`IMM_WIDTH-1:0];

    assign o_rdAddrA = rs;
    assign o_rdAddrB = rt;

    ////////////////////////////////////////////////////////////////////////////
    // Control decode and immediate extension
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        known  = 1'b1;
        aluOp  = corePkg::ALU_ADD;
        useImm = 1'b1;
        dest   = rt;
        // Sign extension unless overridden below
        immExt = {{EXT_WIDTH{imm16[`IMM_WIDTH-1]}}, imm16};
        case (opcode)
            corePkg::OP_SPECIAL: begin
                useImm = 1'b0;
                dest   = rd;
                case (funct)
                    corePkg::FN_ADD: aluOp = corePkg::ALU_ADD;
                    corePkg::FN_SUB: aluOp = corePkg::ALU_SUB;
                    corePkg::FN_AND: aluOp = corePkg::ALU_AND;
                    corePkg::FN_OR:  aluOp = corePkg::ALU_OR;
                    corePkg::FN_XOR: aluOp = corePkg::ALU_XOR;
                    corePkg::FN_NOR: aluOp = corePkg::ALU_NOR;
                    corePkg::FN_SLT: aluOp = corePkg::ALU_SLT;
                    corePkg::FN_SLL: aluOp = corePkg::ALU_SLL;
                    corePkg::FN_SRL: aluOp = corePkg::ALU_SRL;
                    corePkg::FN_SRA: aluOp = corePkg::ALU_SRA;
                    default:         known = 1'b0;
                endcase
            end
            corePkg::OP_ADDI: aluOp = corePkg::ALU_ADD;
            corePkg::OP_SLTI: aluOp = corePkg::ALU_SLT;
            corePkg::OP_ANDI: begin
                aluOp  = corePkg::ALU_AND;
                immExt = {{EXT_WIDTH{1'b0}}, imm16};
            end
            corePkg::OP_ORI: begin
                aluOp  = corePkg::ALU_OR;
                immExt = {{EXT_WIDTH{1'b0}}, imm16};
            end
            corePkg::OP_XORI: begin
                aluOp  = corePkg::ALU_XOR;
                immExt = {{EXT_WIDTH{1'b0}}, imm16};
            end
            corePkg::OP_LUI: begin
                aluOp  = corePkg::ALU_LUI;
                immExt = {imm16, {EXT_WIDTH{1'b0}}};
            end
            default: known = 1'b0;
        endcase
    end

    // Decode/execute register
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            decodedReg.valid <= 1'b0;
        end else begin
            decodedReg <= '{valid: i_instrValid && known, aluOp: aluOp, useImm: useImm,
                            rs: rs, rt: rt, dest: dest, shamt: shamt,
                            regA: i_rdDataA, regB: i_rdDataB, imm: immExt};
        end
    end

    assign o_decoded = decodedReg;

endmodule

//--- hw/executeStage.sv
`timescale 1ns/10ps
`include "core_config.svh"

module executeStage (
    input  logic                i_clk,
    input  logic                i_reset,
    input  corePkg::decodedOp_t i_decoded,
    output corePkg::wbResult_t  o_result
);

    corePkg::wbResult_t     resultReg;
    logic                   fwdA;
    logic                   fwdB;
    logic [`DATA_WIDTH-1:0] opA;
    logic [`DATA_WIDTH-1:0] regBValue;
    logic [`DATA_WIDTH-1:0] opB;
    logic                   lessThan;
    logic [`DATA_WIDTH-1:0] aluOut;

    ////////////////////////////////////////////////////////////////////////////
    // Forwarding from the execute register
    ////////////////////////////////////////////////////////////////////////////

    // Previous instruction's result is still in resultReg
    assign fwdA = resultReg.write && (resultReg.dest != '0)
                  && (resultReg.dest == i_decoded.rs);
    assign fwdB = resultReg.write && (resultReg.dest != '0)
                  && (resultReg.dest == i_decoded.rt);

    assign opA       = fwdA ? resultReg.data : i_decoded.regA;
    assign regBValue = fwdB ? resultReg.data : i_decoded.regB;

    ////////////////////////////////////////////////////////////////////////////
    // ALU control and ALU
    ////////////////////////////////////////////////////////////////////////////

    // Immediate forms take the extended immediate as operand B
    assign opB = i_decoded.useImm ? i_decoded.imm : regBValue;

    assign lessThan = $signed(opA) < $signed(opB);

    always_comb begin
        case (i_decoded.aluOp)
            corePkg::ALU_ADD: aluOut = opA + opB;
            corePkg::ALU_SUB: aluOut = opA - opB;
            corePkg::ALU_AND: aluOut = opA & opB;
            corePkg::ALU_OR:  aluOut = opA | opB;
            corePkg::ALU_XOR: aluOut = opA ^ opB;
            corePkg::ALU_NOR: aluOut = ~(opA | opB);
            corePkg::ALU_SLT: aluOut = {{(`DATA_WIDTH-1){1'b0}}, lessThan};
            // Shifts move operand B by the shamt field
            corePkg::ALU_SLL: aluOut = opB << i_decoded.shamt;
            corePkg::ALU_SRL: aluOut = opB >> i_decoded.shamt;
            corePkg::ALU_SRA: aluOut = $signed(opB) >>> i_decoded.shamt;
            // Already placed in the upper half by decode
            corePkg::ALU_LUI: aluOut = opB;
            default:          aluOut = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Execute/result register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            resultReg.write <= 1'b0;
        end else begin
            resultReg <= '{write: i_decoded.valid, dest: i_decoded.dest, data: aluOut};
        end
    end

    assign o_result = resultReg;

endmodule

//--- hw/pipelineCore.sv
`timescale 1ns/10ps
`include "core_config.svh"

module pipelineCore (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_instrValid,
    input  logic [`DATA_WIDTH-1:0]     i_instr,
    output logic                       o_wbValid,
    output logic [`REG_ADDR_WIDTH-1:0] o_wbDest,
    output logic [`DATA_WIDTH-1:0]     o_wbData
);

    logic [`REG_ADDR_WIDTH-1:0] rdAddrA;
    logic [`REG_ADDR_WIDTH-1:0] rdAddrB;
    logic [`DATA_WIDTH-1:0]     rdDataA;
    logic [`DATA_WIDTH-1:0]     rdDataB;
    corePkg::decodedOp_t        decoded;
    corePkg::wbResult_t         exResult;
    corePkg::wbResult_t         regWrite;

    ////////////////////////////////////////////////////////////////////////////
    // Register file and stages
    ////////////////////////////////////////////////////////////////////////////

    regFile u_regFile (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rdAddrA  (rdAddrA),
        .i_rdAddrB  (rdAddrB),
        .i_wrAddr   (regWrite.dest),
        .i_wrEnable (regWrite.write),
        .i_wrData   (regWrite.data),
        .o_rdDataA  (rdDataA),
        .o_rdDataB  (rdDataB)
    );

    decodeStage u_decodeStage (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_instrValid (i_instrValid),
        .i_instr      (i_instr),
        .i_rdDataA    (rdDataA),
        .i_rdDataB    (rdDataB),
        .o_rdAddrA    (rdAddrA),
        .o_rdAddrB    (rdAddrB),
        .o_decoded    (decoded)
    );

    executeStage u_executeStage (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_decoded (decoded),
        .o_result  (exResult)
    );

    // Write-back and observation
    resultStage u_resultStage (
        .i_result   (exResult),
        .o_regWrite (regWrite),
        .o_wbValid  (o_wbValid),
        .o_wbDest   (o_wbDest),
        .o_wbData   (o_wbData)
    );

endmodule

//--- hw/regFile.sv
`timescale 1ns/10ps
`include "core_config.svh"

module regFile (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic [`REG_ADDR_WIDTH-1:0] i_rdAddrA,
    input  logic [`REG_ADDR_WIDTH-1:0] i_rdAddrB,
    input  logic [`REG_ADDR_WIDTH-1:0] i_wrAddr,
    input  logic                       i_wrEnable,
    input  logic [`DATA_WIDTH-1:0]     i_wrData,
    output logic [`DATA_WIDTH-1:0]     o_rdDataA,
    output logic [`DATA_WIDTH-1:0]     o_rdDataB
);

    // Register 0 has no storage
    logic [`DATA_WIDTH-1:0] regs [1:`REG_COUNT-1];

    // Combinational read with same-cycle write bypass
    always_comb begin
        if (i_rdAddrA == '0) begin
            o_rdDataA = '0;
        end else if (i_wrEnable && (i_wrAddr == i_rdAddrA)) begin
            o_rdDataA = i_wrData;
        end else begin
            o_rdDataA = regs[i_rdAddrA];
        end
    end

    always_comb begin
        if (i_rdAddrB == '0) begin
            o_rdDataB = '0;
        end else if (i_wrEnable && (i_wrAddr == i_rdAddrB)) begin
            o_rdDataB = i_wrData;
        end else begin
            o_rdDataB = regs[i_rdAddrB];
        end
    end

    always_ff @(posedge i_clk) begin
        for (int i = 1; i < `REG_COUNT; i++) begin
            if (i_reset) begin
                regs[i] <= '0;
            end else if (i_wrEnable && (i_wrAddr == `REG_ADDR_WIDTH'(i))) begin
                regs[i] <= i_wrData;
            end
        end
    end

endmodule

//--- hw/resultStage.sv
`timescale 1ns/10ps
`include "core_config.svh"

module resultStage (
    input  corePkg::wbResult_t         i_result,
    output corePkg::wbResult_t         o_regWrite,
    output logic                       o_wbValid,
    output logic [`REG_ADDR_WIDTH-1:0] o_wbDest,
    output logic [`DATA_WIDTH-1:0]     o_wbData
);

    logic               commit;
    corePkg::wbResult_t committed;

    ////////////////////////////////////////////////////////////////////////////
    // Commit gating
    ////////////////////////////////////////////////////////////////////////////

    // Writes to register 0 are dropped here
    assign commit = i_result.write && (i_result.dest != '0);

    assign committed = '{write: commit, dest: i_result.dest, data: i_result.data};

    // Register file write port
    assign o_regWrite = committed;

    // Observation port mirrors the write port
    assign o_wbValid = committed.write;
    assign o_wbDest  = committed.dest;
    assign o_wbData  = committed.data;

endmodule

//--- verif/tbPipelineCore.sv
`timescale 1ns/10ps
`include "core_config.svh"

module tbPipelineCore;

    // MIPS funct and opcode values
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2A;
    localparam logic [5:0] OP_ADDI = 6'h08;
    localparam logic [5:0] OP_SLTI = 6'h0A;
    localparam logic [5:0] OP_ANDI = 6'h0C;
    localparam logic [5:0] OP_ORI  = 6'h0D;
    localparam logic [5:0] OP_XORI = 6'h0E;
    localparam logic [5:0] OP_LUI  = 6'h0F;

    // One table row with the expected write filled in by the model
    typedef struct packed {
        logic                       valid;
        logic [`DATA_WIDTH-1:0]     instr;
        logic                       write;
        logic [`REG_ADDR_WIDTH-1:0] dest;
        logic [`DATA_WIDTH-1:0]     data;
    } tableEntry_t;

    // Write the monitor waits for, and the cycle it is due in
    typedef struct packed {
        logic [`REG_ADDR_WIDTH-1:0] dest;
        logic [`DATA_WIDTH-1:0]     data;
        logic [31:0]                due;
    } expWrite_t;

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       instrValid;
    logic [`DATA_WIDTH-1:0]     instr;
    logic                       wbValid;
    logic [`REG_ADDR_WIDTH-1:0] wbDest;
    logic [`DATA_WIDTH-1:0]     wbData;

    tableEntry_t            stimTable[$];
    string                  testNames[$];
    int                     testStart[$];
    expWrite_t              pending[$];
    logic [`DATA_WIDTH-1:0] refRegs [0:`REG_COUNT-1];
    logic [31:0]            cycleCount;
    int                     checks;
    int                     errors;
    int                     seed;

    pipelineCore UUT (
        .i_clk        (clk),
        .i_reset      (reset),
        .i_instrValid (instrValid),
        .i_instr      (instr),
        .o_wbValid    (wbValid),
        .o_wbDest     (wbDest),
        .o_wbData     (wbData)
    );

    initial begin
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    function automatic logic [31:0] rType(input logic [5:0] fn, input int rd, input int rs,
                                          input int rt, input int sh);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input int rt, input int rs,
                                          input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model run in program order while the table is built
    ////////////////////////////////////////////////////////////////////////////

    task automatic modelStep(inout tableEntry_t entry);
        logic [5:0]  op;
        logic [4:0]  sh;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sImm;
        logic [31:0] zImm;
        logic        known;
        op    = entry.instr[31:26];
        sh    = entry.instr[10:6];
        a     = refRegs[entry.instr[25:21]];
        b     = refRegs[entry.instr[20:16]];
        sImm  = {{16{entry.instr[15]}}, entry.instr[15:0]};
        zImm  = {16'h0000, entry.instr[15:0]};
        known = 1'b1;
        // R-type writes rd, I-type writes rt
        entry.dest = (op == 6'h00) ? entry.instr[15:11] : entry.instr[20:16];
        entry.data = '0;
        case (op)
            6'h00: begin
                case (entry.instr[5:0])
                    FN_ADD:  entry.data = a + b;
                    FN_SUB:  entry.data = a - b;
                    FN_AND:  entry.data = a & b;
                    FN_OR:   entry.data = a | b;
                    FN_XOR:  entry.data = a ^ b;
                    FN_NOR:  entry.data = ~(a | b);
                    FN_SLT:  entry.data = {31'b0, ($signed(a) < $signed(b))};
                    FN_SLL:  entry.data = b << sh;
                    FN_SRL:  entry.data = b >> sh;
                    FN_SRA:  entry.data = $signed(b) >>> sh;
                    default: known = 1'b0;
                endcase
            end
            OP_ADDI: entry.data = a + sImm;
            OP_SLTI: entry.data = {31'b0, ($signed(a) < $signed(sImm))};
            OP_ANDI: entry.data = a & zImm;
            OP_ORI:  entry.data = a | zImm;
            OP_XORI: entry.data = a ^ zImm;
            OP_LUI:  entry.data = {entry.instr[15:0], 16'h0000};
            default: known = 1'b0;
        endcase
        entry.write = entry.valid && known && (entry.dest != '0);
        if (entry.write) begin
            refRegs[entry.dest] = entry.data;
        end
    endtask

    task automatic addInstr(input logic [31:0] word);
        tableEntry_t entry;
        entry = '{valid: 1'b1, instr: word, write: 1'b0, dest: '0, data: '0};
        modelStep(entry);
        stimTable.push_back(entry);
    endtask

    task automatic addIdle();
        tableEntry_t entry;
        entry = '0;
        stimTable.push_back(entry);
    endtask

    task automatic beginTest(input string name);
        testNames.push_back(name);
        testStart.push_back(stimTable.size());
    endtask

    // Random values loaded into r8..r15, then random operations on them
    task automatic addRandom(input int count);
        logic [31:0] rnd;
        int          rd;
        int          rs;
        int          rt;
        int          sh;
        for (int r = 8; r < 16; r++) begin
            rnd = $random(seed);
            addInstr(iType(OP_LUI, r, 0, rnd[31:16]));
            addInstr(iType(OP_ORI, r, r, rnd[15:0]));
        end
        for (int n = 0; n < count; n++) begin
            rnd = $random(seed);
            rd  = 8 + int'(rnd[2:0]);
            rs  = 8 + int'(rnd[5:3]);
            rt  = 8 + int'(rnd[8:6]);
            sh  = int'(rnd[17:13]);
            if (rnd[20:18] == 3'd0) begin
                addIdle();
            end
            case (rnd[12:9])
                4'd0:  addInstr(rType(FN_ADD, rd, rs, rt, 0));
                4'd1:  addInstr(rType(FN_SUB, rd, rs, rt, 0));
                4'd2:  addInstr(rType(FN_AND, rd, rs, rt, 0));
                4'd3:  addInstr(rType(FN_OR, rd, rs, rt, 0));
                4'd4:  addInstr(rType(FN_XOR, rd, rs, rt, 0));
                4'd5:  addInstr(rType(FN_NOR, rd, rs, rt, 0));
                4'd6:  addInstr(rType(FN_SLT, rd, rs, rt, 0));
                4'd7:  addInstr(rType(FN_SLL, rd, 0, rt, sh));
                4'd8:  addInstr(rType(FN_SRL, rd, 0, rt, sh));
                4'd9:  addInstr(rType(FN_SRA, rd, 0, rt, sh));
                4'd10: addInstr(iType(OP_ADDI, rd, rs, rnd[31:16]));
                4'd11: addInstr(iType(OP_SLTI, rd, rs, rnd[31:16]));
                4'd12: addInstr(iType(OP_ANDI, rd, rs, rnd[31:16]));
                4'd13: addInstr(iType(OP_ORI, rd, rs, rnd[31:16]));
                4'd14: addInstr(iType(OP_XORI, rd, rs, rnd[31:16]));
                default: addInstr(iType(OP_LUI, rd, 0, rnd[31:16]));
            endcase
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Driver, monitor and checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic driveEntry(input tableEntry_t entry);
        expWrite_t next;
        @(posedge clk);
        #1;
        instrValid = entry.valid;
        instr      = entry.instr;
        if (entry.write) begin
            next.dest = entry.dest;
            next.data = entry.data;
            next.due  = cycleCount + 2;
            pending.push_back(next);
        end
    endtask

    // Outputs change only on the rising edge
    always @(negedge clk) begin : monitor
        expWrite_t head;
        if (wbValid === 1'b1) begin
            if (pending.size() == 0) begin
                errors++;
                $display("unexpected write of %h to r%0d at %0t ns", wbData, wbDest, $time);
            end else begin
                head = pending.pop_front();
                checkValue("write cycle", cycleCount, head.due);
                checkValue("write dest", 32'(wbDest), 32'(head.dest));
                checkValue("write data", wbData, head.data);
            end
        end else if (wbValid !== 1'b0) begin
            errors++;
            $display("write valid output is unknown at %0t ns", $time);
        end
    end

    task automatic runTest(input string name, input int first, input int last);
        int startChecks;
        int startErrors;
        int waited;
        startChecks = checks;
        startErrors = errors;
        for (int i = first; i < last; i++) begin
            driveEntry(stimTable[i]);
        end
        driveEntry('0);
        waited = 0;
        while (pending.size() > 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (pending.size() > 0) begin
            errors++;
            $display("timeout in test %s: %0d writes never appeared", name, pending.size());
            pending.delete();
        end
        // Quiet cycles catch writes that should not happen
        repeat (4) @(posedge clk);
        $display("test %s: %0d checks, %0d errors", name, checks - startChecks,
                 errors - startErrors);
    endtask

    initial begin
        seed       = 32'h46f4_1932;
        reset      = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        cycleCount = '0;
        checks     = 0;
        errors     = 0;
        for (int r = 0; r < `REG_COUNT; r++) begin
            refRegs[r] = '0;
        end

        beginTest("reset idle");
        beginTest("arith");
        addInstr(iType(OP_ADDI, 1, 0, 16'd100));
        addInstr(iType(OP_ADDI, 2, 0, 16'hFFF9));
        addInstr(iType(OP_LUI, 3, 0, 16'h8000));
        addInstr(iType(OP_ORI, 3, 3, 16'h0011));
        addInstr(rType(FN_ADD, 4, 1, 2, 0));
        addInstr(rType(FN_SUB, 5, 2, 1, 0));
        addInstr(rType(FN_AND, 6, 2, 3, 0));
        addInstr(rType(FN_OR, 7, 1, 3, 0));
        addInstr(rType(FN_XOR, 8, 2, 3, 0));
        addInstr(rType(FN_NOR, 9, 1, 2, 0));
        addInstr(rType(FN_SLT, 10, 2, 1, 0));
        addInstr(rType(FN_SLT, 11, 1, 2, 0));
        addInstr(rType(FN_SLT, 12, 3, 2, 0));
        beginTest("shift");
        addInstr(rType(FN_SLL, 13, 0, 3, 0));
        addInstr(rType(FN_SLL, 13, 0, 3, 1));
        addInstr(rType(FN_SLL, 13, 0, 3, 31));
        addInstr(rType(FN_SRL, 13, 0, 3, 0));
        addInstr(rType(FN_SRL, 13, 0, 3, 1));
        addInstr(rType(FN_SRL, 13, 0, 3, 31));
        addInstr(rType(FN_SRA, 13, 0, 3, 0));
        addInstr(rType(FN_SRA, 13, 0, 3, 1));
        addInstr(rType(FN_SRA, 13, 0, 3, 31));
        beginTest("immediate");
        addInstr(iType(OP_ADDI, 14, 1, 16'h8000));
        addInstr(iType(OP_SLTI, 15, 2, 16'hFFFF));
        addInstr(iType(OP_SLTI, 16, 1, 16'hFFFF));
        addInstr(iType(OP_ANDI, 17, 2, 16'hFFFF));
        addInstr(iType(OP_ORI, 18, 0, 16'h8001));
        addInstr(iType(OP_XORI, 19, 2, 16'h8000));
        addInstr(iType(OP_LUI, 20, 0, 16'hABCD));
        // Producer one behind is forwarded, two behind comes through the register file
        beginTest("forwarding");
        addInstr(iType(OP_ADDI, 21, 0, 16'd5));
        addInstr(rType(FN_ADD, 22, 21, 21, 0));
        addInstr(rType(FN_SUB, 23, 22, 21, 0));
        addInstr(rType(FN_ADD, 24, 23, 22, 0));
        addIdle();
        addIdle();
        addInstr(rType(FN_ADD, 25, 24, 23, 0));
        beginTest("zero and unknown");
        addInstr(iType(OP_ADDI, 0, 0, 16'd123));
        addInstr(rType(FN_ADD, 0, 1, 1, 0));
        addInstr(rType(FN_ADD, 26, 0, 0, 0));
        addInstr(32'h8C22_0000);
        addInstr(32'h0800_0010);
        addInstr(rType(6'h21, 27, 1, 2, 0));
        addIdle();
        addInstr(iType(OP_ORI, 28, 0, 16'h0000));
        beginTest("random");
        addRandom(40);
        testStart.push_back(stimTable.size());

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int t = 0; t < testNames.size(); t++) begin
            runTest(testNames[t], testStart[t], testStart[t + 1]);
        end

        $display("summary: %0d tests, %0d checks, %0d errors", testNames.size(), checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+hw
hw/corePkg.sv
hw/regFile.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/resultStage.sv
hw/pipelineCore.sv
verif/tbPipelineCore.sv
